// ==== video_text.f ====
rtl/video_pkg.sv
rtl/video_timing.sv
rtl/io_regs.sv
rtl/text_fetch.sv
rtl/palette.sv
rtl/video_text.sv
tb/video_text_sva.sv
tb/tb_video_text.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the text-mode VGA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_video_text -f video_text.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_video_text 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb/tb_video_text.sv ====
`timescale 1ns/1ps

module tb_video_text import video_pkg::*; ();

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL + 100;   // Longest legal wait
    localparam int RSP_TIMEOUT  = 4;
    localparam int TEXT_WORDS   = COLUMNS * ROWS;

    typedef enum logic {OP_WRITE, OP_READ} bus_op_e;

    typedef struct packed {
        bus_op_e     op;
        bus_target_e target;
        logic [11:0] addr;
        logic [15:0] data;
        logic [15:0] expected;
    } step_t;

    logic     vclk;
    logic     reset;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    rgb_t     vga_rgb;
    logic     vga_hsync;
    logic     vga_vsync;
    logic     irq;

    // Reference model of the memories
    logic [15:0] tram_model [TRAM_DEPTH];
    logic [7:0]  font_model [FONT_DEPTH];
    rgb_t        pal_model [16];
    step_t       steps [$];
    logic [31:0] lcg_state = 32'd3848;
    int          error_count = 0;

    video_text dut0 (
        .vclk      (vclk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .vga_rgb   (vga_rgb),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .irq       (irq)
    );

    initial begin
        vclk = 1'b0;
        forever #4 vclk = ~vclk;
    end

    initial begin
        #80_000_000;   // About 24 frames
        stop_run("timeout: simulation time limit reached before the test ended");
    end

    ////////////////////
    // Reporting and compares
    ////////////////////
    task automatic stop_run(input string line);
        error_count++;
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic report_error(input string msg);
        stop_run($sformatf("error at %0t ns: %s", $time, msg));
    endtask

    task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp, input string what);
        if (got.valid !== exp.valid || (exp.valid && got.rddata !== exp.rddata))
            report_error($sformatf("%s: response %0b/%h, expected %0b/%h",
                                   what, got.valid, got.rddata, exp.valid, exp.rddata));
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: rgb %h, expected %h", what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // Pixel colour from the text, font and palette rules
    function automatic rgb_t expected_pixel(input int x, input int y, input logic enabled);
        logic [15:0] word;
        logic [7:0]  glyph;
        logic [2:0]  bit_sel;
        logic [3:0]  idx;
        word    = tram_model[12'((y / GLYPH_H) * COLUMNS + x / GLYPH_W)];
        glyph   = font_model[{word[7:0], 4'(y % GLYPH_H)}];
        bit_sel = 3'(GLYPH_W - 1 - (x % GLYPH_W));   // MSB is leftmost
        if (!enabled)
            idx = 4'd0;
        else if (glyph[bit_sel])
            idx = word[15:12];
        else
            idx = word[11:8];
        return pal_model[idx];
    endfunction

    ////////////////////
    // Bus access
    ////////////////////
    task automatic bus_write(input bus_target_e target, input logic [11:0] addr,
                             input logic [15:0] data);
        cpu_req = '{strobe: 1'b1, wr: 1'b1, target: target, addr: addr, wrdata: data};
        @(negedge vclk);
        cpu_req = '0;
        check_rsp(cpu_rsp, '0, "response to a write");
    endtask

    task automatic reg_write(input io_reg_e r, input logic [15:0] data);
        bus_write(TGT_REGS, 12'(r), data);
    endtask

    task automatic bus_read(input bus_target_e target, input logic [11:0] addr,
                            output cpu_rsp_t rsp);
        int cycles;
        cpu_req = '{strobe: 1'b1, wr: 1'b0, target: target, addr: addr, wrdata: 16'h0};
        @(negedge vclk);
        cpu_req = '0;
        cycles  = 1;
        while (!cpu_rsp.valid) begin
            if (cycles >= RSP_TIMEOUT)
                stop_run("no read response arrived after a read strobe");
            @(negedge vclk);
            cycles++;
        end
        if (cycles != 1)
            stop_run("read response arrived later than one cycle after the strobe");
        rsp = cpu_rsp;
    endtask

    task automatic read_expect(input bus_target_e target, input logic [11:0] addr,
                               input logic [15:0] expected, input string what);
        cpu_rsp_t rsp;
        cpu_rsp_t exp_rsp;
        bus_read(target, addr, rsp);
        exp_rsp.valid  = 1'b1;
        exp_rsp.rddata = expected;
        check_rsp(rsp, exp_rsp, what);
    endtask

    ////////////////////
    // Video waits
    ////////////////////
    task automatic wait_sync(input logic vertical, input logic level);
        int count;
        count = 0;
        while ((vertical ? vga_vsync : vga_hsync) !== level) begin
            if (count >= FRAME_CYCLES)
                stop_run("timeout: sync output never reached the awaited level");
            @(negedge vclk);
            count++;
        end
    endtask

    task automatic wait_irq();
        int count;
        count = 0;
        while (irq !== 1'b1) begin
            if (count >= 2 * FRAME_CYCLES)
                stop_run("timeout: irq never rose");
            @(negedge vclk);
            count++;
        end
    endtask

    // Starts on pixel 0 of line y and ends on pixel 0 of the next line
    task automatic scan_line(input logic check, input logic enabled, input int y);
        for (int x = 0; x < H_ACTIVE; x++) begin
            if (check)
                check_rgb(vga_rgb, expected_pixel(x, y, enabled),
                          $sformatf("pixel %0d,%0d", x, y));
            @(negedge vclk);
        end
        for (int x = 0; vga_hsync; x++) begin   // Front porch
            if (check)
                check_rgb(vga_rgb, '0, $sformatf("front porch line %0d", y));
            if (x >= H_TOTAL)
                stop_run("timeout: hsync never fell after the active pixels");
            @(negedge vclk);
        end
        wait_sync(1'b0, 1'b1);
        repeat (H_BACK) begin
            if (check)
                check_rgb(vga_rgb, '0, $sformatf("back porch line %0d", y));
            @(negedge vclk);
        end
    endtask

    task automatic check_frame(input logic enabled);
        wait_sync(1'b1, 1'b0);
        wait_sync(1'b1, 1'b1);
        repeat (V_BACK) scan_line(1'b0, enabled, 0);
        for (int y = 0; y < V_ACTIVE; y++)
            scan_line((y % 97 == 0) || y == 15 || y == 16 || y == V_ACTIVE - 1, enabled, y);
    endtask

    ////////////////////
    // Register table
    ////////////////////
    task automatic build_table();
        steps.push_back(step_t'{OP_WRITE, TGT_REGS, 12'(REG_CTRL),    16'hffff, 16'h0000});
        steps.push_back(step_t'{OP_READ,  TGT_REGS, 12'(REG_CTRL),    16'h0000, 16'h0001});
        steps.push_back(step_t'{OP_WRITE, TGT_REGS, 12'(REG_PALSEL),  16'h00a5, 16'h0000});
        steps.push_back(step_t'{OP_READ,  TGT_REGS, 12'(REG_PALSEL),  16'h0000, 16'h0005});
        steps.push_back(step_t'{OP_WRITE, TGT_REGS, 12'(REG_IRQLINE), 16'hfdef, 16'h0000});
        steps.push_back(step_t'{OP_READ,  TGT_REGS, 12'(REG_IRQLINE), 16'h0000, 16'h01ef});
        steps.push_back(step_t'{OP_WRITE, TGT_REGS, 12'(REG_IRQMASK), 16'hfffe, 16'h0000});
        steps.push_back(step_t'{OP_READ,  TGT_REGS, 12'(REG_IRQMASK), 16'h0000, 16'h0002});
        steps.push_back(step_t'{OP_WRITE, TGT_REGS, 12'(REG_IRQMASK), 16'h0000, 16'h0000});
        steps.push_back(step_t'{OP_WRITE, TGT_REGS, 12'(REG_CTRL),    16'h0000, 16'h0000});
        steps.push_back(step_t'{OP_READ,  TGT_REGS, 12'(REG_CTRL),    16'h0000, 16'h0000});
        steps.push_back(step_t'{OP_READ,  TGT_REGS, 12'd7,            16'h0000, 16'h0000});
        steps.push_back(step_t'{OP_WRITE, TGT_REGS, 12'(REG_PALSEL),  16'h0003, 16'h0000});
        steps.push_back(step_t'{OP_WRITE, TGT_REGS, 12'(REG_PALDATA), 16'hf123, 16'h0000});
        steps.push_back(step_t'{OP_READ,  TGT_REGS, 12'(REG_PALDATA), 16'h0000, 16'h0123});
        steps.push_back(step_t'{OP_WRITE, TGT_TRAM, 12'h005,          16'hbeef, 16'h0000});
        steps.push_back(step_t'{OP_READ,  TGT_TRAM, 12'h005,          16'h0000, 16'hbeef});
        steps.push_back(step_t'{OP_WRITE, TGT_FONT, 12'h010,          16'h1234, 16'h0000});
        steps.push_back(step_t'{OP_READ,  TGT_FONT, 12'h010,          16'h0000, 16'h0034});
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        cpu_rsp_t    rsp;
        logic [15:0] word;
        reset   = 1'b1;
        cpu_req = '0;
        repeat (5) @(negedge vclk);
        check_bit(irq, 1'b0, "irq in reset");
        check_bit(vga_hsync, 1'b1, "hsync in reset");
        check_bit(vga_vsync, 1'b1, "vsync in reset");
        check_rgb(vga_rgb, '0, "rgb in reset");
        check_rsp(cpu_rsp, '0, "response in reset");
        reset = 1'b0;
        @(negedge vclk);

        build_table();
        foreach (steps[i]) begin
            if (steps[i].op == OP_WRITE)
                bus_write(steps[i].target, steps[i].addr, steps[i].data);
            else
                read_expect(steps[i].target, steps[i].addr, steps[i].expected,
                            $sformatf("table step %0d", i));
        end

        // Random text, font and palette
        for (int i = 0; i < TEXT_WORDS; i++) begin
            tram_model[12'(i)] = lcg_next();
            bus_write(TGT_TRAM, 12'(i), tram_model[12'(i)]);
        end
        for (int i = 0; i < FONT_DEPTH; i++) begin
            word = lcg_next();
            font_model[12'(i)] = word[7:0];
            bus_write(TGT_FONT, 12'(i), {8'h00, word[7:0]});
        end
        for (int i = 0; i < 16; i++) begin
            word = lcg_next();
            pal_model[4'(i)] = rgb_t'(word[11:0]);
            reg_write(REG_PALSEL, 16'(i));
            reg_write(REG_PALDATA, word);
        end
        for (int i = 0; i < TEXT_WORDS; i++)
            read_expect(TGT_TRAM, 12'(i), tram_model[12'(i)], "text readback");
        for (int i = 0; i < FONT_DEPTH; i++)
            read_expect(TGT_FONT, 12'(i), {8'h00, font_model[12'(i)]}, "font readback");
        for (int i = 0; i < 16; i++) begin
            reg_write(REG_PALSEL, 16'(i));
            read_expect(TGT_REGS, 12'(REG_PALDATA), {4'h0, pal_model[4'(i)]},
                        "palette readback");
        end

        reg_write(REG_CTRL, 16'h0001);
        check_frame(1'b1);
        reg_write(REG_CTRL, 16'h0000);
        check_frame(1'b0);   // Every active pixel shows entry 0

        // Line interrupt at line 100
        reg_write(REG_IRQMASK, 16'h0000);
        reg_write(REG_IRQLINE, 16'd100);
        wait_sync(1'b1, 1'b0);
        reg_write(REG_IRQSTAT, 16'h0003);
        reg_write(REG_IRQMASK, 16'h0002);
        check_bit(irq, 1'b0, "irq after status clear");
        wait_irq();
        read_expect(TGT_REGS, 12'(REG_VLINE), 16'd100, "vline at line irq");
        reg_write(REG_IRQSTAT, 16'h0002);
        check_bit(irq, 1'b0, "irq after line status clear");

        // Vblank interrupt, then a masked status bit
        reg_write(REG_IRQLINE, 16'h03ff);   // Never matches
        reg_write(REG_IRQSTAT, 16'h0003);
        reg_write(REG_IRQMASK, 16'h0001);
        check_bit(irq, 1'b0, "irq before vblank");
        wait_irq();
        bus_read(TGT_REGS, 12'(REG_VLINE), rsp);
        check_bit(rsp.rddata >= 16'(V_ACTIVE), 1'b1, "vline in vertical blank");
        reg_write(REG_IRQMASK, 16'h0002);
        reg_write(REG_IRQSTAT, 16'h0003);
        check_bit(irq, 1'b0, "irq after vblank clear");
        wait_sync(1'b1, 1'b0);
        wait_sync(1'b1, 1'b1);
        wait_sync(1'b1, 1'b0);
        read_expect(TGT_REGS, 12'(REG_IRQSTAT), 16'h0001, "masked vblank status");
        check_bit(irq, 1'b0, "irq with vblank masked");

        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== tb/video_text_sva.sv ====
`timescale 1ns/1ps

module video_text_sva import video_pkg::*; (
    input logic       vclk,
    input logic       reset,
    input cpu_req_t   cpu_req,
    input cpu_rsp_t   cpu_rsp,
    input rgb_t       vga_rgb,
    input logic       vga_hsync,
    input logic       irq,
    input logic [1:0] irqstat
);

    logic [1:0] mask_seen;   // Mask as written over the bus

    always_ff @(posedge vclk or posedge reset) begin
        if (reset)
            mask_seen <= '0;
        else if (cpu_req.strobe && cpu_req.wr && cpu_req.target == TGT_REGS &&
                 cpu_req.addr == 12'(REG_IRQMASK))
            mask_seen <= cpu_req.wrdata[1:0];
    end

    ////////////////////
    // Bus response
    ////////////////////
    property read_answered;
        @(posedge vclk) disable iff (reset)
            (cpu_req.strobe && !cpu_req.wr) |=> cpu_rsp.valid;
    endproperty
    a_read_answered: assert property (read_answered)
        else $error("read strobe without a response one cycle later");

    ////////////////////
    // Blanking and interrupt
    ////////////////////
    property dark_in_hsync;
        @(posedge vclk) disable iff (reset) !vga_hsync |-> (vga_rgb == '0);
    endproperty
    a_dark_in_hsync: assert property (dark_in_hsync)
        else $error("pixel colour present during horizontal sync");

    property irq_needs_enabled_status;
        @(posedge vclk) disable iff (reset) ((irqstat & mask_seen) == 2'b00) |-> !irq;
    endproperty
    a_irq_quiet: assert property (irq_needs_enabled_status)
        else $error("irq high with no enabled status bit");

endmodule

// Checker on the DUT, dut0 in the bench
bind video_text video_text_sva u_sva (
    .vclk      (vclk),
    .reset     (reset),
    .cpu_req   (cpu_req),
    .cpu_rsp   (cpu_rsp),
    .vga_rgb   (vga_rgb),
    .vga_hsync (vga_hsync),
    .irq       (irq),
    .irqstat   (u_regs.irqstat_q)
);

// ==== rtl/video_text.sv ====
`timescale 1ns/1ps

module video_text import video_pkg::*; (
    input  logic     vclk,
    input  logic     reset,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp,
    output rgb_t     vga_rgb,
    output logic     vga_hsync,
    output logic     vga_vsync,
    output logic     irq
);

    scan_t       scan;
    cpu_req_t    tram_req;
    cpu_req_t    font_req;
    logic [15:0] tram_rddata;
    logic [7:0]  font_rddata;
    pal_wr_t     pal_wr;
    logic [3:0]  pal_rd_index;
    rgb_t        pal_rddata;
    logic        text_enable;
    logic [3:0]  colour_index;
    logic        pixel_active;

    logic [PIXEL_LATENCY-1:0] hsync_sr;
    logic [PIXEL_LATENCY-1:0] vsync_sr;

    video_timing u_timing (
        .vclk  (vclk),
        .reset (reset),
        .scan  (scan)
    );

    io_regs u_regs (
        .vclk         (vclk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .scan         (scan),
        .tram_rddata  (tram_rddata),
        .font_rddata  (font_rddata),
        .pal_rddata   (pal_rddata),
        .cpu_rsp      (cpu_rsp),
        .tram_req     (tram_req),
        .font_req     (font_req),
        .pal_wr       (pal_wr),
        .pal_rd_index (pal_rd_index),
        .text_enable  (text_enable),
        .irq          (irq)
    );

    text_fetch u_fetch (
        .vclk         (vclk),
        .reset        (reset),
        .tram_req     (tram_req),
        .font_req     (font_req),
        .scan         (scan),
        .text_enable  (text_enable),
        .tram_rddata  (tram_rddata),
        .font_rddata  (font_rddata),
        .colour_index (colour_index),
        .pixel_active (pixel_active)
    );

    palette u_palette (
        .vclk         (vclk),
        .reset        (reset),
        .pal_wr       (pal_wr),
        .pal_rd_index (pal_rd_index),
        .colour_index (colour_index),
        .pixel_active (pixel_active),
        .pal_rddata   (pal_rddata),
        .rgb          (vga_rgb)
    );

    ////////////////////
    // Sync alignment
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            hsync_sr <= '1;   // Inactive high
            vsync_sr <= '1;
        end else begin
            hsync_sr <= {hsync_sr[PIXEL_LATENCY-2:0], scan.hsync};
            vsync_sr <= {vsync_sr[PIXEL_LATENCY-2:0], scan.vsync};
        end
    end

    assign vga_hsync = hsync_sr[PIXEL_LATENCY-1];
    assign vga_vsync = vsync_sr[PIXEL_LATENCY-1];

endmodule

// ==== rtl/palette.sv ====
`timescale 1ns/1ps

module palette import video_pkg::*; (
    input  logic       vclk,
    input  logic       reset,
    input  pal_wr_t    pal_wr,
    input  logic [3:0] pal_rd_index,
    input  logic [3:0] colour_index,
    input  logic       pixel_active,
    output rgb_t       pal_rddata,
    output rgb_t       rgb
);

    rgb_t entries [16];

    ////////////////////
    // Entry storage
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++)
                entries[i] <= '0;
        end else if (pal_wr.strobe) begin
            entries[pal_wr.index] <= pal_wr.colour;
        end
    end

    assign pal_rddata = entries[pal_rd_index];   // CPU readback

    ////////////////////
    // Pixel output
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            rgb <= '0;
        end else if (pixel_active) begin
            rgb <= entries[colour_index];
        end else begin
            rgb <= '0;   // Blanking
        end
    end

endmodule

// ==== rtl/text_fetch.sv ====
`timescale 1ns/1ps

module text_fetch import video_pkg::*; (
    input  logic        vclk,
    input  logic        reset,
    input  cpu_req_t    tram_req,
    input  cpu_req_t    font_req,
    input  scan_t       scan,
    input  logic        text_enable,
    output logic [15:0] tram_rddata,
    output logic [7:0]  font_rddata,
    output logic [3:0]  colour_index,
    output logic        pixel_active
);

    logic [15:0] tram_mem [TRAM_DEPTH];
    logic [7:0]  font_mem [FONT_DEPTH];

    logic [11:0] row_base;
    logic [11:0] char_addr;
    logic [11:0] char_addr_next;
    logic        line_end;

    logic [15:0]          text_q;                  // Stage 1
    logic [LINE_BITS-1:0] glyph_line_q;
    logic [PIX_BITS-1:0]  pix_q;
    logic                 active_q;
    logic [7:0]           glyph_q;                 // Stage 2
    logic [7:0]           colour_q;
    logic [PIX_BITS-1:0]  pix_qq;
    logic                 active_qq;
    logic                 glyph_bit;

    ////////////////////
    // CPU ports
    ////////////////////
    always_ff @(posedge vclk) begin
        if (tram_req.strobe && tram_req.wr)
            tram_mem[tram_req.addr] <= tram_req.wrdata;
        tram_rddata <= tram_mem[tram_req.addr];
    end

    always_ff @(posedge vclk) begin
        if (font_req.strobe && font_req.wr)
            font_mem[font_req.addr] <= font_req.wrdata[7:0];
        font_rddata <= font_mem[font_req.addr];
    end

    ////////////////////
    // Character address
    ////////////////////
    assign line_end = (scan.hpos == 10'(H_TOTAL - 1));

    always_comb begin
        char_addr_next = char_addr;
        if (scan.line_start)
            char_addr_next = row_base;
        else if (scan.hpos[PIX_BITS-1:0] == '0)
            char_addr_next = char_addr + 12'd1;   // Next cell
    end

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            row_base  <= '0;
            char_addr <= '0;
        end else begin
            char_addr <= char_addr_next;
            if (scan.vblank_start)
                row_base <= '0;
            else if (line_end && scan.vpos < 10'(ROWS * GLYPH_H) &&
                     scan.vpos[LINE_BITS-1:0] == LINE_BITS'(GLYPH_H - 1))
                row_base <= row_base + 12'(COLUMNS);   // Last glyph line of the row
        end
    end

    ////////////////////
    // Video ports
    ////////////////////
    always_ff @(posedge vclk) begin
        text_q       <= tram_mem[char_addr_next];
        glyph_line_q <= scan.vpos[LINE_BITS-1:0];
        pix_q        <= scan.hpos[PIX_BITS-1:0];

        glyph_q  <= font_mem[{text_q[7:0], glyph_line_q}];
        colour_q <= text_q[15:8];
        pix_qq   <= pix_q;
    end

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            active_q  <= 1'b0;
            active_qq <= 1'b0;
        end else begin
            active_q  <= scan.active;
            active_qq <= active_q;
        end
    end

    // Leftmost pixel is the glyph MSB
    assign glyph_bit = glyph_q[PIX_BITS'(GLYPH_W - 1) - pix_qq];

    always_comb begin
        if (!text_enable)
            colour_index = 4'd0;
        else if (glyph_bit)
            colour_index = colour_q[7:4];   // Foreground
        else
            colour_index = colour_q[3:0];   // Background
    end

    assign pixel_active = active_qq;

endmodule

// ==== rtl/io_regs.sv ====
`timescale 1ns/1ps

module io_regs import video_pkg::*; (
    input  logic        vclk,
    input  logic        reset,
    input  cpu_req_t    cpu_req,
    input  scan_t       scan,
    input  logic [15:0] tram_rddata,
    input  logic [7:0]  font_rddata,
    input  rgb_t        pal_rddata,
    output cpu_rsp_t    cpu_rsp,
    output cpu_req_t    tram_req,
    output cpu_req_t    font_req,
    output pal_wr_t     pal_wr,
    output logic [3:0]  pal_rd_index,
    output logic        text_enable,
    output logic        irq
);

    logic        reg_wr;
    io_reg_e     reg_addr;
    logic        rd_strobe;

    logic        ctrl_q;        // Text enable
    logic [3:0]  palsel_q;
    logic [9:0]  irqline_q;
    logic [1:0]  irqmask_q;
    logic [1:0]  irqstat_q;

    logic        match;
    logic        match_q;
    logic [1:0]  irq_set;
    logic [1:0]  irq_clr;

    logic [15:0] reg_rddata;
    logic [15:0] reg_rddata_q;
    bus_target_e rd_target_q;
    logic        rd_valid_q;

    assign reg_addr  = io_reg_e'(cpu_req.addr[2:0]);
    assign reg_wr    = cpu_req.strobe && cpu_req.wr && (cpu_req.target == TGT_REGS);
    assign rd_strobe = cpu_req.strobe && !cpu_req.wr;

    // RAM requests only strobe for their own target
    always_comb begin
        tram_req        = cpu_req;
        tram_req.strobe = cpu_req.strobe && (cpu_req.target == TGT_TRAM);
        font_req        = cpu_req;
        font_req.strobe = cpu_req.strobe && (cpu_req.target == TGT_FONT);
    end

    assign pal_wr.strobe = reg_wr && (reg_addr == REG_PALDATA);
    assign pal_wr.index  = palsel_q;
    assign pal_wr.colour = rgb_t'(cpu_req.wrdata[11:0]);
    assign pal_rd_index  = palsel_q;
    assign text_enable   = ctrl_q;

    ////////////////////
    // Interrupts
    ////////////////////
    assign match = (scan.vpos == irqline_q);

    always_comb begin
        irq_set             = '0;
        irq_set[IRQ_LINE]   = match && !match_q;   // First cycle of the line
        irq_set[IRQ_VBLANK] = scan.vblank_start;
        irq_clr = (reg_wr && reg_addr == REG_IRQSTAT) ? cpu_req.wrdata[1:0] : 2'b00;
    end

    assign irq = |(irqstat_q & irqmask_q);

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            ctrl_q    <= 1'b0;
            palsel_q  <= '0;
            irqline_q <= '0;
            irqmask_q <= '0;
            irqstat_q <= '0;
            match_q   <= 1'b1;   // No line event straight out of reset
        end else begin
            match_q <= match;
            if (reg_wr) begin
                case (reg_addr)
                    REG_CTRL:    ctrl_q    <= cpu_req.wrdata[0];
                    REG_PALSEL:  palsel_q  <= cpu_req.wrdata[3:0];
                    REG_IRQLINE: irqline_q <= cpu_req.wrdata[9:0];
                    REG_IRQMASK: irqmask_q <= cpu_req.wrdata[1:0];
                    default:     ;
                endcase
            end
            irqstat_q <= (irqstat_q & ~irq_clr) | irq_set;   // Set wins over clear
        end
    end

    ////////////////////
    // Read response
    ////////////////////
    always_comb begin
        case (reg_addr)
            REG_CTRL:    reg_rddata = {15'd0, ctrl_q};
            REG_PALSEL:  reg_rddata = {12'd0, palsel_q};
            REG_PALDATA: reg_rddata = {4'd0, pal_rddata};
            REG_VLINE:   reg_rddata = {6'd0, scan.vpos};
            REG_IRQLINE: reg_rddata = {6'd0, irqline_q};
            REG_IRQMASK: reg_rddata = {14'd0, irqmask_q};
            REG_IRQSTAT: reg_rddata = {14'd0, irqstat_q};
            default:     reg_rddata = '0;
        endcase
    end

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            rd_valid_q  <= 1'b0;
            rd_target_q <= TGT_REGS;
        end else begin
            rd_valid_q  <= rd_strobe;
            if (rd_strobe)
                rd_target_q <= cpu_req.target;
        end
    end

    always_ff @(posedge vclk) begin
        if (rd_strobe)
            reg_rddata_q <= reg_rddata;
    end

    always_comb begin
        cpu_rsp.valid = rd_valid_q;
        case (rd_target_q)
            TGT_TRAM: cpu_rsp.rddata = tram_rddata;
            TGT_FONT: cpu_rsp.rddata = {8'd0, font_rddata};
            default:  cpu_rsp.rddata = reg_rddata_q;
        endcase
    end

endmodule

// ==== rtl/video_timing.sv ====
`timescale 1ns/1ps

module video_timing import video_pkg::*; (
    input  logic  vclk,
    input  logic  reset,
    output scan_t scan
);

    logic [9:0] hpos;
    logic [9:0] vpos;
    logic       hlast;
    logic       vlast;

    assign hlast = (hpos == 10'(H_TOTAL - 1));
    assign vlast = (vpos == 10'(V_TOTAL - 1));

    ////////////////////
    // Counters
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            hpos <= '0;
            vpos <= '0;
        end else begin
            if (hlast) begin
                hpos <= '0;
                if (vlast)
                    vpos <= '0;
                else
                    vpos <= vpos + 10'd1;
            end else begin
                hpos <= hpos + 10'd1;
            end
        end
    end

    ////////////////////
    // Decode
    ////////////////////
    always_comb begin
        scan.hpos = hpos;
        scan.vpos = vpos;

        // Both syncs active low
        scan.hsync = !(hpos >= 10'(H_ACTIVE + H_FRONT) &&
                       hpos <  10'(H_ACTIVE + H_FRONT + H_SYNC));
        scan.vsync = !(vpos >= 10'(V_ACTIVE + V_FRONT) &&
                       vpos <  10'(V_ACTIVE + V_FRONT + V_SYNC));

        scan.active       = (hpos < 10'(H_ACTIVE)) && (vpos < 10'(V_ACTIVE));
        scan.line_start   = (hpos == 10'd0);
        scan.vblank_start = (hpos == 10'd0) && (vpos == 10'(V_ACTIVE));
    end

endmodule

// ==== rtl/video_pkg.sv ====
package video_pkg;

    ////////////////////
    // Frame geometry
    ////////////////////
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;   // 800

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;   // 525

    ////////////////////
    // Text geometry
    ////////////////////
    localparam int COLUMNS    = 80;
    localparam int ROWS       = 30;
    localparam int GLYPH_W    = 8;
    localparam int GLYPH_H    = 16;
    localparam int PIX_BITS   = $clog2(GLYPH_W);
    localparam int LINE_BITS  = $clog2(GLYPH_H);
    localparam int TRAM_DEPTH = 4096;   // 2400 words in use
    localparam int FONT_DEPTH = 4096;   // 256 glyphs of 16 rows

    localparam int PIXEL_LATENCY = 3;   // Counters to registered RGB

    // Interrupt status and mask bit positions
    localparam int IRQ_VBLANK = 0;
    localparam int IRQ_LINE   = 1;

    typedef enum logic [1:0] {TGT_REGS, TGT_TRAM, TGT_FONT} bus_target_e;

    typedef enum logic [2:0] {
        REG_CTRL, REG_PALSEL, REG_PALDATA, REG_VLINE,
        REG_IRQLINE, REG_IRQMASK, REG_IRQSTAT
    } io_reg_e;

    typedef struct packed {
        logic        strobe;
        logic        wr;
        bus_target_e target;
        logic [11:0] addr;
        logic [15:0] wrdata;
    } cpu_req_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] rddata;
    } cpu_rsp_t;

    typedef struct packed {
        logic [9:0] hpos;
        logic [9:0] vpos;
        logic       hsync;
        logic       vsync;
        logic       active;
        logic       line_start;
        logic       vblank_start;
    } scan_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic       strobe;
        logic [3:0] index;
        rgb_t       colour;
    } pal_wr_t;

endpackage
